//--- bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// Direct-mapped BTB size
`define BP_BTB_ENTRIES 16

// History length, also the PHT index width
`define BP_GHR_BITS 4

// In-flight predictions, power of two
`define BP_QUEUE_DEPTH 4

`endif

//--- bp_pkg.sv
`default_nettype none

`include "bp_config.svh"

package bp_pkg;

    // RISC-V control-flow opcodes
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // 2-bit saturating counter
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_MAX         = 2'd3;
    localparam ctr_t CTR_MIN         = 2'd0;
    localparam ctr_t CTR_WEAK_TAKEN  = 2'd2;

    // One prediction waiting for its resolution
    typedef struct packed {
        logic [31:0]              pc;
        logic [6:0]               op;
        logic [`BP_GHR_BITS-1:0]  pht_idx;
        logic                     pred_taken;
        logic [31:0]              pred_target;
    } pred_rec_t;

endpackage

`default_nettype wire

//--- bp_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_predictor (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic [31:0]             lookup_pc_i,
    output logic                         hit_taken_o,
    output logic [31:0]                  hit_target_o,
    output logic [`BP_GHR_BITS-1:0]      pht_idx_o,
    input  wire logic                    pht_we_i,
    input  wire logic                    pht_inc_i,
    input  wire logic [`BP_GHR_BITS-1:0] pht_widx_i,
    input  wire logic                    ghr_shift_i,
    input  wire logic                    ghr_bit_i,
    input  wire logic                    btb_we_i,
    input  wire logic [31:0]             btb_pc_i,
    input  wire logic [6:0]              btb_op_i,
    input  wire logic [31:0]             btb_target_i
);
    import bp_pkg::*;

    localparam int IW = $clog2(`BP_BTB_ENTRIES);
    localparam int PHT_SIZE = 1 << `BP_GHR_BITS;

    logic [31:0] btb_target [`BP_BTB_ENTRIES];
    logic [31:0] btb_tag    [`BP_BTB_ENTRIES];
    logic        btb_jump   [`BP_BTB_ENTRIES];
    logic        btb_branch [`BP_BTB_ENTRIES];
    logic        btb_valid  [`BP_BTB_ENTRIES];

    ctr_t                    pht [PHT_SIZE];
    logic [`BP_GHR_BITS-1:0] ghr;

    logic [IW-1:0] ridx;
    logic [IW-1:0] widx;
    logic          btb_hit;
    logic [31:0]   target_byp;

    assign ridx = lookup_pc_i[IW+1:2];
    assign widx = btb_pc_i[IW+1:2];

    // gshare index
    assign pht_idx_o = lookup_pc_i[`BP_GHR_BITS+1:2] ^ ghr;

    assign btb_hit = btb_valid[ridx] && (btb_tag[ridx] == lookup_pc_i);

    // Only the target is forwarded from a same-cycle write
    assign target_byp = (btb_we_i && widx == ridx) ? btb_target_i : btb_target[ridx];

    assign hit_taken_o = btb_hit &&
        (btb_jump[ridx] || (btb_branch[ridx] && pht[pht_idx_o][1]));
    assign hit_target_o = btb_hit ? target_byp : 32'b0;

    always_ff @(posedge clk) begin
        if (btb_we_i) begin
            btb_target[widx] <= btb_target_i;
            btb_tag[widx]    <= btb_pc_i;
            btb_jump[widx]   <= (btb_op_i == OP_JAL) || (btb_op_i == OP_JALR);
            btb_branch[widx] <= (btb_op_i == OP_BRANCH);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else if (btb_we_i) begin
            btb_valid[widx] <= 1'b1;
        end
    end

    // Counters saturate at both ends
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_SIZE; i++) begin
                pht[i] <= CTR_WEAK_TAKEN;
            end
        end else if (pht_we_i) begin
            if (pht_inc_i && pht[pht_widx_i] != CTR_MAX) begin
                pht[pht_widx_i] <= pht[pht_widx_i] + 2'd1;
            end else if (!pht_inc_i && pht[pht_widx_i] != CTR_MIN) begin
                pht[pht_widx_i] <= pht[pht_widx_i] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr <= '0;
        end else if (ghr_shift_i) begin
            ghr <= {ghr[`BP_GHR_BITS-2:0], ghr_bit_i};
        end
    end

endmodule

`default_nettype wire

//--- bp_lookup_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_lookup_stage (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    req_valid_i,
    input  wire logic [31:0]             req_pc_i,
    input  wire logic [6:0]              req_op_i,
    output logic                         req_ready_o,
    output logic [31:0]                  lookup_pc_o,
    input  wire logic                    hit_taken_i,
    input  wire logic [31:0]             hit_target_i,
    input  wire logic [`BP_GHR_BITS-1:0] pht_idx_i,
    input  wire logic                    full_i,
    output logic                         push_o,
    output bp_pkg::pred_rec_t            push_data_o,
    output logic                         pred_valid_o,
    output logic                         pred_taken_o,
    output logic [31:0]                  pred_target_o
);
    import bp_pkg::*;

    logic accept;

    assign req_ready_o = !full_i;
    assign accept      = req_valid_i && req_ready_o;
    assign lookup_pc_o = req_pc_i;

    // Record goes into the queue on the accepting edge
    assign push_o                  = accept;
    assign push_data_o.pc          = req_pc_i;
    assign push_data_o.op          = req_op_i;
    assign push_data_o.pht_idx     = pht_idx_i;
    assign push_data_o.pred_taken  = hit_taken_i;
    assign push_data_o.pred_target = hit_target_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pred_valid_o <= 1'b0;
        end else begin
            pred_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pred_taken_o  <= hit_taken_i;
            pred_target_o <= hit_target_i;
        end
    end

endmodule

`default_nettype wire

//--- bp_pending_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_pending_fifo #(
    parameter type T = logic [31:0]
) (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire logic push_i,
    input  wire T     push_data_i,
    output logic      full_o,
    input  wire logic pop_i,
    output T          pop_data_o,
    output logic      empty_o
);

    localparam int AW = $clog2(`BP_QUEUE_DEPTH);

    T mem [`BP_QUEUE_DEPTH];

    // Top bit marks the lap around the buffer
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]) && (wr_ptr[AW] != rd_ptr[AW]);

    assign pop_data_o = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr[AW-1:0]] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bp_update_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_update_unit (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                res_valid_i,
    input  wire logic                res_taken_i,
    input  wire logic [31:0]         res_target_i,
    output logic                     res_ready_o,
    input  wire logic                empty_i,
    output logic                     pop_o,
    input  wire bp_pkg::pred_rec_t   pop_data_i,
    output logic                     pht_we_o,
    output logic                     pht_inc_o,
    output logic [`BP_GHR_BITS-1:0]  pht_widx_o,
    output logic                     ghr_shift_o,
    output logic                     ghr_bit_o,
    output logic                     btb_we_o,
    output logic [31:0]              btb_pc_o,
    output logic [6:0]               btb_op_o,
    output logic [31:0]              btb_target_o,
    output logic                     mispredict_o,
    output logic [31:0]              redirect_pc_o
);
    import bp_pkg::*;

    logic accept;
    logic is_branch;
    logic is_jump;
    logic wrong;

    assign res_ready_o = !empty_i;
    assign accept      = res_valid_i && res_ready_o;
    assign pop_o       = accept;

    assign is_branch = (pop_data_i.op == OP_BRANCH);
    assign is_jump   = (pop_data_i.op == OP_JAL) || (pop_data_i.op == OP_JALR);

    // Direction history is trained by conditional branches only
    assign pht_we_o    = accept && is_branch;
    assign pht_inc_o   = res_taken_i;
    assign pht_widx_o  = pop_data_i.pht_idx;
    assign ghr_shift_o = accept && is_branch;
    assign ghr_bit_o   = res_taken_i;

    assign btb_we_o     = accept && res_taken_i && (is_branch || is_jump);
    assign btb_pc_o     = pop_data_i.pc;
    assign btb_op_o     = pop_data_i.op;
    assign btb_target_o = res_target_i;

    assign wrong = (pop_data_i.pred_taken != res_taken_i) ||
                   (res_taken_i && pop_data_i.pred_target != res_target_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mispredict_o <= 1'b0;
        end else begin
            mispredict_o <= accept && wrong;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            redirect_pc_o <= res_taken_i ? res_target_i : pop_data_i.pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

//--- bp_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_top (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        req_valid_i,
    input  wire logic [31:0] req_pc_i,
    input  wire logic [6:0]  req_op_i,
    output logic             req_ready_o,
    output logic             pred_valid_o,
    output logic             pred_taken_o,
    output logic [31:0]      pred_target_o,
    input  wire logic        res_valid_i,
    input  wire logic        res_taken_i,
    input  wire logic [31:0] res_target_i,
    output logic             res_ready_o,
    output logic             mispredict_o,
    output logic [31:0]      redirect_pc_o
);
    import bp_pkg::*;

    logic [31:0]             lookup_pc;
    logic                    hit_taken;
    logic [31:0]             hit_target;
    logic [`BP_GHR_BITS-1:0] pht_idx;

    logic                    pht_we;
    logic                    pht_inc;
    logic [`BP_GHR_BITS-1:0] pht_widx;
    logic                    ghr_shift;
    logic                    ghr_bit;
    logic                    btb_we;
    logic [31:0]             btb_pc;
    logic [6:0]              btb_op;
    logic [31:0]             btb_target;

    logic      push;
    logic      pop;
    logic      full;
    logic      empty;
    pred_rec_t push_data;
    pred_rec_t pop_data;

    bp_predictor u_predictor (
        .clk          (clk),
        .reset_i      (reset_i),
        .lookup_pc_i  (lookup_pc),
        .hit_taken_o  (hit_taken),
        .hit_target_o (hit_target),
        .pht_idx_o    (pht_idx),
        .pht_we_i     (pht_we),
        .pht_inc_i    (pht_inc),
        .pht_widx_i   (pht_widx),
        .ghr_shift_i  (ghr_shift),
        .ghr_bit_i    (ghr_bit),
        .btb_we_i     (btb_we),
        .btb_pc_i     (btb_pc),
        .btb_op_i     (btb_op),
        .btb_target_i (btb_target)
    );

    bp_lookup_stage u_lookup (
        .clk           (clk),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_pc_i      (req_pc_i),
        .req_op_i      (req_op_i),
        .req_ready_o   (req_ready_o),
        .lookup_pc_o   (lookup_pc),
        .hit_taken_i   (hit_taken),
        .hit_target_i  (hit_target),
        .pht_idx_i     (pht_idx),
        .full_i        (full),
        .push_o        (push),
        .push_data_o   (push_data),
        .pred_valid_o  (pred_valid_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o)
    );

    bp_pending_fifo #(
        .T (pred_rec_t)
    ) u_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (push_data),
        .full_o      (full),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .empty_o     (empty)
    );

    bp_update_unit u_update (
        .clk           (clk),
        .reset_i       (reset_i),
        .res_valid_i   (res_valid_i),
        .res_taken_i   (res_taken_i),
        .res_target_i  (res_target_i),
        .res_ready_o   (res_ready_o),
        .empty_i       (empty),
        .pop_o         (pop),
        .pop_data_i    (pop_data),
        .pht_we_o      (pht_we),
        .pht_inc_o     (pht_inc),
        .pht_widx_o    (pht_widx),
        .ghr_shift_o   (ghr_shift),
        .ghr_bit_o     (ghr_bit),
        .btb_we_o      (btb_we),
        .btb_pc_o      (btb_pc),
        .btb_op_o      (btb_op),
        .btb_target_o  (btb_target),
        .mispredict_o  (mispredict_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

`default_nettype wire

//--- bp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bp_checker (
    input wire logic clk,
    input wire logic reset_i,
    input wire logic req_valid_i,
    input wire logic req_ready_i,
    input wire logic res_valid_i,
    input wire logic res_ready_i,
    input wire logic pred_valid_i,
    input wire logic mispredict_i,
    input wire logic push_i,
    input wire logic pop_i,
    input wire logic full_i,
    input wire logic empty_i
);

    // Registered outputs stay low through reset and the cycle after
    a_reset_quiet: assert property (@(posedge clk)
        reset_i |=> !pred_valid_i && !mispredict_i)
        else $error("pred_valid_o or mispredict_o high after a reset cycle");

    a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
        !(push_i && full_i))
        else $error("push into a full pending queue");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset_i)
        !(pop_i && empty_i))
        else $error("pop from an empty pending queue");

    a_pred_after_req: assert property (@(posedge clk) disable iff (reset_i)
        pred_valid_i |-> $past(req_valid_i && req_ready_i))
        else $error("pred_valid_o without an accepted request");

    a_misp_after_res: assert property (@(posedge clk) disable iff (reset_i)
        mispredict_i |-> $past(res_valid_i && res_ready_i))
        else $error("mispredict_o without an accepted resolution");

endmodule

bind bp_top bp_checker u_checker (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_ready_i  (req_ready_o),
    .res_valid_i  (res_valid_i),
    .res_ready_i  (res_ready_o),
    .pred_valid_i (pred_valid_o),
    .mispredict_i (mispredict_o),
    .push_i       (push),
    .pop_i        (pop),
    .full_i       (full),
    .empty_i      (empty)
);

`default_nettype wire

//--- tb_bp_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bp_top;

    localparam int TIMEOUT_CYCLES = 100;

    logic        clk;
    logic        reset_i;
    logic        req_valid_i;
    logic [31:0] req_pc_i;
    logic [6:0]  req_op_i;
    logic        req_ready_o;
    logic        pred_valid_o;
    logic        pred_taken_o;
    logic [31:0] pred_target_o;
    logic        res_valid_i;
    logic        res_taken_i;
    logic [31:0] res_target_i;
    logic        res_ready_o;
    logic        mispredict_o;
    logic [31:0] redirect_pc_o;

    bp_top UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_pc_i      (req_pc_i),
        .req_op_i      (req_op_i),
        .req_ready_o   (req_ready_o),
        .pred_valid_o  (pred_valid_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o),
        .res_valid_i   (res_valid_i),
        .res_taken_i   (res_taken_i),
        .res_target_i  (res_target_i),
        .res_ready_o   (res_ready_o),
        .mispredict_o  (mispredict_o),
        .redirect_pc_o (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Called 2 ns after a rising edge, returns at the same phase
    task automatic run_request(input logic [31:0] pc, input logic [6:0] op,
                               input logic exp_taken, input logic [31:0] exp_target);
        int cycles;
        req_valid_i = 1'b1;
        req_pc_i    = pc;
        req_op_i    = op;
        cycles      = 0;
        while (!req_ready_o) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure("Timed out waiting for req_ready_o to go high");
            end
        end
        @(posedge clk);
        #2;
        req_valid_i = 1'b0;
        cycles      = 0;
        while (!pred_valid_o) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure("Timed out waiting for pred_valid_o");
            end
        end
        check_bit("pred_taken_o", pred_taken_o, exp_taken);
        check_word("pred_target_o", pred_target_o, exp_target);
    endtask

    // Verdict is registered, so it is read one cycle after acceptance
    task automatic run_resolution(input logic taken, input logic [31:0] target,
                                  input logic exp_mispredict, input logic [31:0] exp_redirect);
        int cycles;
        res_valid_i  = 1'b1;
        res_taken_i  = taken;
        res_target_i = target;
        cycles       = 0;
        while (!res_ready_o) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure("Timed out waiting for res_ready_o to go high");
            end
        end
        @(posedge clk);
        #2;
        res_valid_i = 1'b0;
        check_bit("mispredict_o", mispredict_o, exp_mispredict);
        check_word("redirect_pc_o", redirect_pc_o, exp_redirect);
    endtask

    initial begin
        int          fd;
        int          n;
        int          lines_run;
        logic        done;
        logic [7:0]  cmd;
        logic [31:0] pc;
        logic [31:0] op;
        logic [31:0] taken;
        logic [31:0] target;
        logic [31:0] exp_a;
        logic [31:0] exp_b;

        reset_i      = 1'b1;
        req_valid_i  = 1'b0;
        req_pc_i     = '0;
        req_op_i     = '0;
        res_valid_i  = 1'b0;
        res_taken_i  = 1'b0;
        res_target_i = '0;
        lines_run    = 0;
        done         = 1'b0;

        fd = $fopen("bp_stim.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open bp_stim.txt for reading");
        end

        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;

        // Quiet, empty queue out of reset
        check_bit("pred_valid_o", pred_valid_o, 1'b0);
        check_bit("mispredict_o", mispredict_o, 1'b0);
        check_bit("req_ready_o", req_ready_o, 1'b1);
        check_bit("res_ready_o", res_ready_o, 1'b0);

        while (!done) begin
            n = $fscanf(fd, " %c %h %h %h %h %h %h", cmd, pc, op, taken, target, exp_a, exp_b);
            if (n == 7) begin
                case (cmd)
                    "R": run_request(pc, op[6:0], exp_a[0], exp_b);
                    "S": run_resolution(taken[0], target, exp_a[0], exp_b);
                    "Q": begin
                        check_bit("req_ready_o", req_ready_o, exp_a[0]);
                        check_bit("res_ready_o", res_ready_o, exp_b[0]);
                    end
                    default: begin
                        stop_with_failure($sformatf("Unknown command '%c' in bp_stim.txt", cmd));
                    end
                endcase
                lines_run++;
            end else if (n <= 0 && $feof(fd)) begin
                done = 1'b1;
            end else begin
                stop_with_failure($sformatf("Malformed line %0d in bp_stim.txt", lines_run + 1));
            end
        end
        $fclose(fd);

        if (lines_run == 0) begin
            stop_with_failure("No stimulus lines were read from bp_stim.txt");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bp_stim.txt
R 00000100 63 0 00000000 0 00000000
S 00000000 00 1 00000200 1 00000200
R 00000100 63 0 00000000 1 00000200
S 00000000 00 1 00000200 0 00000200
R 00000100 63 0 00000000 1 00000200
S 00000000 00 0 00000000 1 00000104
R 00000100 63 0 00000000 1 00000200
S 00000000 00 0 00000000 1 00000104
R 00000100 63 0 00000000 1 00000200
S 00000000 00 0 00000000 1 00000104
R 00000100 63 0 00000000 1 00000200
S 00000000 00 0 00000000 1 00000104
R 00000100 63 0 00000000 1 00000200
S 00000000 00 0 00000000 1 00000104
R 00000100 63 0 00000000 1 00000200
S 00000000 00 0 00000000 1 00000104
R 00000100 63 0 00000000 0 00000200
S 00000000 00 0 00000000 0 00000104
R 00000100 63 0 00000000 0 00000200
S 00000000 00 0 00000000 0 00000104
R 0000010c 6f 0 00000000 0 00000000
S 00000000 00 1 00000400 1 00000400
R 0000010c 6f 0 00000000 1 00000400
S 00000000 00 1 00000400 0 00000400
R 00000110 67 0 00000000 0 00000000
S 00000000 00 1 00000500 1 00000500
R 00000110 67 0 00000000 1 00000500
S 00000000 00 1 00000580 1 00000580
R 00000110 67 0 00000000 1 00000580
S 00000000 00 1 00000580 0 00000580
R 0000010c 6f 0 00000000 1 00000400
R 00000110 67 0 00000000 1 00000580
R 00000100 63 0 00000000 0 00000200
R 0000010c 6f 0 00000000 1 00000400
Q 00000000 00 0 00000000 0 00000001
S 00000000 00 1 00000400 0 00000400
R 00000110 67 0 00000000 1 00000580
S 00000000 00 1 00000580 0 00000580
S 00000000 00 0 00000000 0 00000104
S 00000000 00 1 00000440 1 00000440
S 00000000 00 1 00000580 0 00000580
Q 00000000 00 0 00000000 1 00000000

//--- list.f
+incdir+.
bp_pkg.sv
bp_predictor.sv
bp_lookup_stage.sv
bp_pending_fifo.sv
bp_update_unit.sv
bp_top.sv
bp_checker.sv
tb_bp_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bp_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
